/* include/core_consts.svh */
// rv64i core constants
// widths and reset fetch address

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

//////////////////////////////////////////////////
// datapath widths

`define CORE_XLEN     64              // data and address width
`define CORE_ILEN     32              // instruction word
`define CORE_RADDR_W  5               // register index

//////////////////////////////////////////////////
// reset state

`define CORE_PC_START 64'h8000_0000   // first fetch address

`endif

/* hdl/core_pkg.sv */
// rv64i core types
// opcodes, alu operations, instruction views

`include "core_consts.svh"

package core_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_EQ,     // branch compare, result in bit 0
    ALU_NE,
    ALU_PASS    // second operand through
  } alu_op_e;

  // register-register layout, also carries branch immediate bits
  typedef struct packed {
    logic [6:0]               funct7;
    logic [`CORE_RADDR_W-1:0] rs2;
    logic [`CORE_RADDR_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [`CORE_RADDR_W-1:0] rd;
    opcode_e                  opcode;
  } r_fields_s;

  // immediate layout, also carries jal immediate bits
  typedef struct packed {
    logic [11:0]              imm;
    logic [`CORE_RADDR_W-1:0] rs1;
    logic [2:0]               funct3;
    logic [`CORE_RADDR_W-1:0] rd;
    opcode_e                  opcode;
  } i_fields_s;

  typedef union packed {
    r_fields_s r;
    i_fields_s i;
  } inst_u;

endpackage

/* hdl/stage_if.sv */
// stage link interfaces
// decode to execute, execute to writeback

`timescale 1ns/1ps
`include "core_consts.svh"

interface dec_exec_if import core_pkg::*; ();
  logic                     valid;      // one-cycle pulse
  alu_op_e                  alu_op;
  opcode_e                  opcode;
  logic [`CORE_XLEN-1:0]    op_a;
  logic [`CORE_XLEN-1:0]    op_b;       // rs2 or immediate
  logic [`CORE_XLEN-1:0]    imm;        // branch and jump offset
  logic [`CORE_RADDR_W-1:0] rd;
  logic                     rd_we;
  logic [`CORE_XLEN-1:0]    pc;
  logic [`CORE_XLEN-1:0]    pc_pred;    // pc+4 from fetch

  modport src (output valid, alu_op, opcode, op_a, op_b, imm, rd, rd_we, pc, pc_pred);
  modport dst (input  valid, alu_op, opcode, op_a, op_b, imm, rd, rd_we, pc, pc_pred);
endinterface

interface exec_wb_if ();
  logic                     valid;      // one-cycle pulse
  logic [`CORE_RADDR_W-1:0] rd;
  logic                     rd_we;
  logic [`CORE_XLEN-1:0]    result;
  logic [`CORE_XLEN-1:0]    pc;
  logic                     jump;       // taken branch or jal
  logic [`CORE_XLEN-1:0]    jump_addr;

  modport src (output valid, rd, rd_we, result, pc, jump, jump_addr);
  modport dst (input  valid, rd, rd_we, result, pc, jump, jump_addr);
endinterface

/* hdl/fetch_unit.sv */
// rv64i fetch unit
// bus fetch and jump redirection

`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst,

  //////////////////////////////////////////////////
  // instruction bus
  input  logic                  i_bus_ack,
  input  logic [`CORE_ILEN-1:0] i_bus_rdata,
  output logic                  o_bus_req,
  output logic [`CORE_XLEN-1:0] o_bus_addr,

  //////////////////////////////////////////////////
  // writeback feedback and decode side
  input  logic                  i_wb_done,      // previous instruction retired
  input  logic                  i_pc_jmp,
  input  logic [`CORE_XLEN-1:0] i_pc_jmpaddr,
  output logic [`CORE_XLEN-1:0] o_pc,
  output logic [`CORE_XLEN-1:0] o_pc_pred,      // predicted next pc
  output logic [`CORE_ILEN-1:0] o_inst,
  output logic                  o_fetched       // word available pulse
);

  logic xfer_done;
  logic redirect;

  assign xfer_done = o_bus_req & i_bus_ack;

  // jump target differs from the sequential guess
  assign redirect = i_wb_done & i_pc_jmp & (i_pc_jmpaddr != o_pc_pred);

  // request level, one transfer per retired instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req <= 1'b1;                  // first fetch straight out of reset
    end else if (xfer_done) begin
      o_bus_req <= 1'b0;
    end else if (i_wb_done) begin
      o_bus_req <= 1'b1;                  // restart
    end
  end

  // fetch address
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_addr <= `CORE_PC_START;
    end else if (xfer_done) begin
      o_bus_addr <= o_bus_addr + 4;
    end else if (redirect) begin
      // holds the jump target until the next request goes out
      o_bus_addr <= i_pc_jmpaddr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_fetched <= 1'b0;
    end else begin
      o_fetched <= xfer_done;
    end
  end

  // word and its pc, held until the next transfer
  always_ff @(posedge clk) begin
    if (xfer_done) begin
      o_pc      <= o_bus_addr;
      o_pc_pred <= o_bus_addr + 4;
      o_inst    <= i_bus_rdata;
    end
  end

endmodule

/* hdl/reg_file.sv */
// integer register file
// two read ports, one write port

`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`CORE_RADDR_W-1:0] i_raddr_a,
  input  logic [`CORE_RADDR_W-1:0] i_raddr_b,
  input  logic                     i_we,
  input  logic [`CORE_RADDR_W-1:0] i_waddr,
  input  logic [`CORE_XLEN-1:0]    i_wdata,
  output logic [`CORE_XLEN-1:0]    o_rdata_a,
  output logic [`CORE_XLEN-1:0]    o_rdata_b
);

  logic [`CORE_XLEN-1:0] regs [0:31];     // entry 0 never written

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // combinational reads, x0 forced to zero
  assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
  assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

/* hdl/inst_decode.sv */
// rv64i instruction decode
// operand read and immediate forming

`timescale 1ns/1ps
`include "core_consts.svh"

module inst_decode
  import core_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_fetched,
  input  logic [`CORE_XLEN-1:0]    i_pc,
  input  logic [`CORE_XLEN-1:0]    i_pc_pred,
  input  logic [`CORE_ILEN-1:0]    i_inst,
  input  logic [`CORE_XLEN-1:0]    i_rdata_a,
  input  logic [`CORE_XLEN-1:0]    i_rdata_b,
  output logic [`CORE_RADDR_W-1:0] o_raddr_a,
  output logic [`CORE_RADDR_W-1:0] o_raddr_b,
  dec_exec_if.src                  o_dx
);

  inst_u                 inst;
  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] imm_j;
  logic [`CORE_XLEN-1:0] imm;
  alu_op_e               alu_op;
  logic                  use_imm;
  logic                  rd_we;

  assign inst = inst_u'(i_inst);

  //////////////////////////////////////////////////
  // immediates, all sign extended
  assign imm_i = {{(`CORE_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
  // b-type bits sit in the funct7 and rd slots
  assign imm_b = {{(`CORE_XLEN-13){inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rd[0],
                  inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
  // j-type spreads over imm, rs1 and funct3
  assign imm_j = {{(`CORE_XLEN-21){inst.i.imm[11]}}, inst.i.imm[11], inst.i.rs1,
                  inst.i.funct3, inst.i.imm[0], inst.i.imm[10:1], 1'b0};

  always_comb begin
    alu_op  = ALU_PASS;
    use_imm = 1'b0;
    rd_we   = 1'b0;
    imm     = imm_i;
    case (inst.r.opcode)
      OPC_OP: begin
        rd_we = 1'b1;
        case (inst.r.funct3)
          3'b000:  alu_op = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: rd_we  = 1'b0;   // unsupported funct, no-op
        endcase
      end
      OPC_OP_IMM: begin
        rd_we   = 1'b1;
        use_imm = 1'b1;
        case (inst.i.funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: rd_we  = 1'b0;
        endcase
      end
      OPC_JAL: begin
        rd_we = 1'b1;               // link written in execute
        imm   = imm_j;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        case (inst.r.funct3)
          3'b000:  alu_op = ALU_EQ;
          3'b001:  alu_op = ALU_NE;
          default: alu_op = ALU_PASS; // never taken
        endcase
      end
      default: ;                    // unknown opcode retires with no effect
    endcase
  end

  assign o_raddr_a = inst.r.rs1;
  assign o_raddr_b = inst.r.rs2;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_dx.valid <= 1'b0;
    end else begin
      o_dx.valid <= i_fetched;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      o_dx.alu_op  <= alu_op;
      o_dx.opcode  <= inst.r.opcode;
      o_dx.op_a    <= i_rdata_a;
      o_dx.op_b    <= use_imm ? imm : i_rdata_b;
      o_dx.imm     <= imm;
      o_dx.rd      <= rd_we ? inst.r.rd : '0;   // rd reads zero when nothing is written
      o_dx.rd_we   <= rd_we;
      o_dx.pc      <= i_pc;
      o_dx.pc_pred <= i_pc_pred;
    end
  end

endmodule

/* hdl/alu_execute.sv */
// rv64i execute
// alu, branch compare and jump target

`timescale 1ns/1ps
`include "core_consts.svh"

module alu_execute
  import core_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  dec_exec_if.dst i_dx,
  exec_wb_if.src  o_xw
);

  logic [`CORE_XLEN-1:0] alu_res;
  logic [`CORE_XLEN-1:0] result;
  logic [`CORE_XLEN-1:0] target;
  logic                  taken;
  logic                  jump;

  always_comb begin
    case (i_dx.alu_op)
      ALU_ADD: alu_res = i_dx.op_a + i_dx.op_b;
      ALU_SUB: alu_res = i_dx.op_a - i_dx.op_b;
      ALU_AND: alu_res = i_dx.op_a & i_dx.op_b;
      ALU_OR:  alu_res = i_dx.op_a | i_dx.op_b;
      ALU_XOR: alu_res = i_dx.op_a ^ i_dx.op_b;
      ALU_EQ:  alu_res = {{(`CORE_XLEN-1){1'b0}}, i_dx.op_a == i_dx.op_b};
      ALU_NE:  alu_res = {{(`CORE_XLEN-1){1'b0}}, i_dx.op_a != i_dx.op_b};
      default: alu_res = i_dx.op_b;   // pass
    endcase
  end

  // only a real compare can take a branch
  assign taken  = ((i_dx.alu_op == ALU_EQ) || (i_dx.alu_op == ALU_NE)) && alu_res[0];
  assign target = i_dx.pc + i_dx.imm;

  always_comb begin
    result = alu_res;
    jump   = 1'b0;
    case (i_dx.opcode)
      OPC_JAL: begin
        result = i_dx.pc_pred;        // link is pc+4
        jump   = 1'b1;
      end
      OPC_BRANCH: jump = taken;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_xw.valid <= 1'b0;
    end else begin
      o_xw.valid <= i_dx.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_dx.valid) begin
      o_xw.rd        <= i_dx.rd;
      o_xw.rd_we     <= i_dx.rd_we;
      o_xw.result    <= result;
      o_xw.pc        <= i_dx.pc;
      o_xw.jump      <= jump;
      o_xw.jump_addr <= target;
    end
  end

endmodule

/* hdl/writeback_stage.sv */
// rv64i writeback
// register write, retire report, fetch restart

`timescale 1ns/1ps
`include "core_consts.svh"

module writeback_stage (
  input  logic                     clk,
  input  logic                     rst,
  exec_wb_if.dst                   i_xw,

  // register file write port
  output logic                     o_rf_we,
  output logic [`CORE_RADDR_W-1:0] o_rf_waddr,
  output logic [`CORE_XLEN-1:0]    o_rf_wdata,

  // back to fetch
  output logic                     o_wb_done,
  output logic                     o_pc_jmp,
  output logic [`CORE_XLEN-1:0]    o_pc_jmpaddr,

  // retire report
  output logic                     o_ret_valid,
  output logic [`CORE_XLEN-1:0]    o_ret_pc,
  output logic [`CORE_RADDR_W-1:0] o_ret_rd,
  output logic                     o_ret_we,
  output logic [`CORE_XLEN-1:0]    o_ret_data
);

  logic                     valid_q;
  logic [`CORE_RADDR_W-1:0] rd_q;
  logic                     we_q;
  logic [`CORE_XLEN-1:0]    data_q;
  logic [`CORE_XLEN-1:0]    pc_q;
  logic                     jump_q;
  logic [`CORE_XLEN-1:0]    jaddr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_xw.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_xw.valid) begin
      rd_q    <= i_xw.rd;
      we_q    <= i_xw.rd_we;
      data_q  <= i_xw.result;
      pc_q    <= i_xw.pc;
      jump_q  <= i_xw.jump;
      jaddr_q <= i_xw.jump_addr;
    end
  end

  //////////////////////////////////////////////////
  // everything below comes from the one registered result
  assign o_rf_we      = valid_q & we_q;
  assign o_rf_waddr   = rd_q;
  assign o_rf_wdata   = data_q;

  assign o_wb_done    = valid_q;
  assign o_pc_jmp     = valid_q & jump_q;
  assign o_pc_jmpaddr = jaddr_q;

  assign o_ret_valid  = valid_q;
  assign o_ret_pc     = pc_q;
  assign o_ret_rd     = rd_q;
  assign o_ret_we     = we_q;
  assign o_ret_data   = data_q;

endmodule

/* hdl/core_top.sv */
// rv64i multi-cycle core
// stages, register file and bus ports

`timescale 1ns/1ps
`include "core_consts.svh"

module core_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_bus_ack,
  input  logic [`CORE_ILEN-1:0]    i_bus_rdata,
  output logic                     o_bus_req,
  output logic [`CORE_XLEN-1:0]    o_bus_addr,
  output logic                     o_ret_valid,
  output logic [`CORE_XLEN-1:0]    o_ret_pc,
  output logic [`CORE_RADDR_W-1:0] o_ret_rd,
  output logic                     o_ret_we,
  output logic [`CORE_XLEN-1:0]    o_ret_data
);

  // fetch to decode
  logic                     fetched;
  logic [`CORE_XLEN-1:0]    pc;
  logic [`CORE_XLEN-1:0]    pc_pred;
  logic [`CORE_ILEN-1:0]    inst;

  // register file
  logic [`CORE_RADDR_W-1:0] raddr_a;
  logic [`CORE_RADDR_W-1:0] raddr_b;
  logic [`CORE_XLEN-1:0]    rdata_a;
  logic [`CORE_XLEN-1:0]    rdata_b;
  logic                     rf_we;
  logic [`CORE_RADDR_W-1:0] rf_waddr;
  logic [`CORE_XLEN-1:0]    rf_wdata;

  // writeback to fetch
  logic                     wb_done;
  logic                     pc_jmp;
  logic [`CORE_XLEN-1:0]    pc_jmpaddr;

  dec_exec_if dx ();
  exec_wb_if  xw ();

  fetch_unit fetch_unit_i (
    .clk          (clk),
    .rst          (rst),
    .i_bus_ack    (i_bus_ack),
    .i_bus_rdata  (i_bus_rdata),
    .o_bus_req    (o_bus_req),
    .o_bus_addr   (o_bus_addr),
    .i_wb_done    (wb_done),
    .i_pc_jmp     (pc_jmp),
    .i_pc_jmpaddr (pc_jmpaddr),
    .o_pc         (pc),
    .o_pc_pred    (pc_pred),
    .o_inst       (inst),
    .o_fetched    (fetched)
  );

  reg_file reg_file_i (
    .clk       (clk),
    .rst       (rst),
    .i_raddr_a (raddr_a),
    .i_raddr_b (raddr_b),
    .i_we      (rf_we),
    .i_waddr   (rf_waddr),
    .i_wdata   (rf_wdata),
    .o_rdata_a (rdata_a),
    .o_rdata_b (rdata_b)
  );

  inst_decode inst_decode_i (
    .clk       (clk),
    .rst       (rst),
    .i_fetched (fetched),
    .i_pc      (pc),
    .i_pc_pred (pc_pred),
    .i_inst    (inst),
    .i_rdata_a (rdata_a),
    .i_rdata_b (rdata_b),
    .o_raddr_a (raddr_a),
    .o_raddr_b (raddr_b),
    .o_dx      (dx.src)
  );

  alu_execute alu_execute_i (
    .clk  (clk),
    .rst  (rst),
    .i_dx (dx.dst),
    .o_xw (xw.src)
  );

  writeback_stage writeback_stage_i (
    .clk          (clk),
    .rst          (rst),
    .i_xw         (xw.dst),
    .o_rf_we      (rf_we),
    .o_rf_waddr   (rf_waddr),
    .o_rf_wdata   (rf_wdata),
    .o_wb_done    (wb_done),
    .o_pc_jmp     (pc_jmp),
    .o_pc_jmpaddr (pc_jmpaddr),
    .o_ret_valid  (o_ret_valid),
    .o_ret_pc     (o_ret_pc),
    .o_ret_rd     (o_ret_rd),
    .o_ret_we     (o_ret_we),
    .o_ret_data   (o_ret_data)
  );

endmodule

/* dv/core_checker.sv */
// retire checker
// isa model of the rv64i subset

`timescale 1ns/1ps
`include "core_consts.svh"

module core_checker
  import core_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_bus_req,
  input  logic                     i_bus_ack,
  input  logic [`CORE_XLEN-1:0]    i_bus_addr,
  input  logic                     i_ret_valid,
  input  logic [`CORE_XLEN-1:0]    i_ret_pc,
  input  logic [`CORE_RADDR_W-1:0] i_ret_rd,
  input  logic                     i_ret_we,
  input  logic [`CORE_XLEN-1:0]    i_ret_data,
  output int                       o_ret_count,
  output int                       o_mismatch_count,
  output int                       o_protocol_count
);

  logic [`CORE_XLEN-1:0]    model_pc;
  logic [`CORE_XLEN-1:0]    model_regs [0:31];
  logic                     req_q;          // request level at the previous edge
  int                       xfers;
  int                       rets;
  int                       mismatches;
  int                       protocol_errs;
  logic                     exp_we;
  logic [`CORE_RADDR_W-1:0] exp_rd;
  logic [`CORE_XLEN-1:0]    exp_data;

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      $display("MISMATCH %s expected %h got %h at retirement %0d", name, exp, got, rets);
      mismatches++;
    end
  endtask

  task automatic report_protocol(input string what);
    $display("ERROR: %s (transfers %0d, retirements %0d)", what, xfers, rets);
    protocol_errs++;
  endtask

  //////////////////////////////////////////////////
  // reference step, one instruction at model_pc
  task automatic run_model(output logic we, output logic [4:0] rd, output logic [63:0] data);
    logic [31:0] word;
    inst_u       w;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic [63:0] next_pc;
    word    = core_tb.rom[model_pc[9:2]];   // rom wraps every 1 KiB
    w       = word;
    a       = model_regs[w.r.rs1];
    b       = model_regs[w.r.rs2];
    imm_i   = {{52{word[31]}}, word[31:20]};
    imm_b   = {{51{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    imm_j   = {{43{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    we      = 1'b0;
    rd      = w.r.rd;
    data    = '0;
    next_pc = model_pc + 4;
    case (w.r.opcode)
      OPC_OP: begin
        we = 1'b1;
        case (w.r.funct3)
          3'b000:  data = (w.r.funct7 == 7'h20) ? a - b : a + b;
          3'b100:  data = a ^ b;
          3'b110:  data = a | b;
          3'b111:  data = a & b;
          default: we = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        we = 1'b1;
        case (w.i.funct3)
          3'b000:  data = a + imm_i;
          3'b100:  data = a ^ imm_i;
          3'b110:  data = a | imm_i;
          3'b111:  data = a & imm_i;
          default: we = 1'b0;
        endcase
      end
      OPC_JAL: begin
        we      = 1'b1;
        data    = model_pc + 4;             // link
        next_pc = model_pc + imm_j;
      end
      OPC_BRANCH: begin
        if ((w.r.funct3 == 3'b000 && a == b) || (w.r.funct3 == 3'b001 && a != b)) begin
          next_pc = model_pc + imm_b;
        end
      end
      default: ;                            // retires as a no-op
    endcase
    if (we && rd != 0) begin
      model_regs[rd] = data;
    end
    model_pc = next_pc;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      model_pc = `CORE_PC_START;
      for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
      end
      req_q         = 1'b0;
      xfers         = 0;
      rets          = 0;
      mismatches    = 0;
      protocol_errs = 0;
    end else begin
      // bus discipline, one instruction in flight
      if (i_bus_req && !req_q && xfers != rets) begin
        report_protocol("bus request raised before the previous instruction retired");
      end
      if (i_bus_req && i_bus_ack) begin
        if (xfers == 0) begin
          check_value("o_bus_addr", `CORE_PC_START, i_bus_addr);
        end
        if (xfers != rets) begin
          report_protocol("bus transfer completed while an instruction was in flight");
        end
        xfers++;
      end
      if (i_ret_valid) begin
        if (rets >= xfers) begin
          report_protocol("instruction retired without a completed bus transfer");
        end
        check_value("o_ret_pc", model_pc, i_ret_pc);
        run_model(exp_we, exp_rd, exp_data);
        check_value("o_ret_we", exp_we, i_ret_we);
        if (exp_we) begin                   // rd and data only mean something on a write
          check_value("o_ret_rd", exp_rd, i_ret_rd);
          check_value("o_ret_data", exp_data, i_ret_data);
        end
        rets++;
      end
      req_q = i_bus_req;
    end
    o_ret_count      <= rets;
    o_mismatch_count <= mismatches;
    o_protocol_count <= protocol_errs;
  end

endmodule

/* dv/core_tb.sv */
// core testbench
// random program rom and bus responder

`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb
  import core_pkg::*;
();

  localparam int RUN_LEN    = 200;
  localparam int MAX_DELAY  = 3;
  localparam int ROUND_TRIP = 6;            // req rise to next req rise at zero delay
  localparam int TIMEOUT    = RUN_LEN * (MAX_DELAY + ROUND_TRIP) + 100;

  logic                     clk;
  logic                     rst;
  logic                     bus_ack   = 1'b0;
  logic [`CORE_ILEN-1:0]    bus_rdata = '0;
  logic                     bus_req;
  logic [`CORE_XLEN-1:0]    bus_addr;
  logic                     ret_valid;
  logic [`CORE_XLEN-1:0]    ret_pc;
  logic [`CORE_RADDR_W-1:0] ret_rd;
  logic                     ret_we;
  logic [`CORE_XLEN-1:0]    ret_data;

  logic [31:0]              rom [0:255];    // read by the checker too
  logic [31:0]              seed;
  logic [1:0]               delay;
  int                       cycles;
  int                       ret_count;
  int                       mismatch_count;
  int                       protocol_count;
  logic                     timed_out;

  //////////////////////////////////////////////////
  // random sources

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {16'h0, seed[31:16]};            // low lcg bits repeat too soon
  endfunction

  function automatic logic [20:0] pick_offset();
    logic [31:0] r;
    int          idx;
    r   = next_random();
    idx = r[3:0];
    // -32..-4 and 4..32, never zero
    if (idx < 8) begin
      return 21'((idx - 8) * 4);
    end
    return 21'((idx - 7) * 4);
  endfunction

  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [20:0] off;
    logic [31:0] word;
    r    = next_random();
    rd   = r[4:0];
    rs1  = r[9:5];
    rs2  = r[14:10];
    r    = next_random();
    imm  = r[11:0];
    off  = pick_offset();
    r    = next_random();
    case (r % 12)
      0:  word = {7'h00, rs2, rs1, 3'b000, rd, OPC_OP};     // add
      1:  word = {7'h20, rs2, rs1, 3'b000, rd, OPC_OP};     // sub
      2:  word = {7'h00, rs2, rs1, 3'b111, rd, OPC_OP};
      3:  word = {7'h00, rs2, rs1, 3'b110, rd, OPC_OP};
      4:  word = {7'h00, rs2, rs1, 3'b100, rd, OPC_OP};
      5:  word = {imm, rs1, 3'b000, rd, OPC_OP_IMM};        // addi
      6:  word = {imm, rs1, 3'b111, rd, OPC_OP_IMM};
      7:  word = {imm, rs1, 3'b110, rd, OPC_OP_IMM};
      8:  word = {imm, rs1, 3'b100, rd, OPC_OP_IMM};
      9:  word = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
      10: word = {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
      default: word = {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], OPC_BRANCH};
    endcase
    return word;
  endfunction

  //////////////////////////////////////////////////
  // clock, dut, checker

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  core_top core_top_i (
    .clk         (clk),
    .rst         (rst),
    .i_bus_ack   (bus_ack),
    .i_bus_rdata (bus_rdata),
    .o_bus_req   (bus_req),
    .o_bus_addr  (bus_addr),
    .o_ret_valid (ret_valid),
    .o_ret_pc    (ret_pc),
    .o_ret_rd    (ret_rd),
    .o_ret_we    (ret_we),
    .o_ret_data  (ret_data)
  );

  core_checker core_checker_i (
    .clk              (clk),
    .rst              (rst),
    .i_bus_req        (bus_req),
    .i_bus_ack        (bus_ack),
    .i_bus_addr       (bus_addr),
    .i_ret_valid      (ret_valid),
    .i_ret_pc         (ret_pc),
    .i_ret_rd         (ret_rd),
    .i_ret_we         (ret_we),
    .i_ret_data       (ret_data),
    .o_ret_count      (ret_count),
    .o_mismatch_count (mismatch_count),
    .o_protocol_count (protocol_count)
  );

  // memory side, ack after 0..3 cycles of seen request
  always @(posedge clk) begin
    if (rst) begin
      bus_ack <= 1'b0;
      delay   <= next_random() % 4;
    end else if (bus_ack) begin
      bus_ack <= 1'b0;                      // transfer completes on this edge
      delay   <= next_random() % 4;
    end else if (bus_req) begin
      if (delay == 0) begin
        bus_ack   <= 1'b1;
        bus_rdata <= rom[bus_addr[9:2]];
      end else begin
        delay <= delay - 1;
      end
    end
  end

  initial begin
    seed = 32'h5632;
    rst  = 1'b1;
    for (int i = 0; i < 256; i++) begin
      rom[i] = random_inst();
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    cycles = 0;
    while (ret_count < RUN_LEN && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    timed_out = (ret_count < RUN_LEN);
    if (timed_out) begin
      $display("ERROR: core stalled, %0d of %0d instructions retired in %0d cycles",
               ret_count, RUN_LEN, cycles);
    end
    $display("retired %0d, mismatches %0d, protocol errors %0d, timeouts %0d",
             ret_count, mismatch_count, protocol_count, timed_out);
    if (!timed_out && mismatch_count == 0 && protocol_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/writeback_stage.sv
hdl/core_top.sv
dv/core_checker.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: rv64i_core

export_include_dirs:
  - include

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/stage_if.sv
      - hdl/fetch_unit.sv
      - hdl/reg_file.sv
      - hdl/inst_decode.sv
      - hdl/alu_execute.sv
      - hdl/writeback_stage.sv
      - hdl/core_top.sv
  - target: simulation
    files:
      - dv/core_checker.sv
      - dv/core_tb.sv
